// ==== common/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32
`define RV_REGS 32

// fetch starts here after reset
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 32'd4

`endif

// ==== common/rvIsaPkg.sv ====
`include "rv_settings.svh"

package rvIsaPkg;

    typedef logic [`RV_XLEN-1:0] word;
    typedef logic [4:0] regIdx;

    // only the opcodes this core executes
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8
    } aluOp;

    typedef struct packed {
        logic [6:0] funct7;
        regIdx      rs2;
        regIdx      rs1;
        logic [2:0] funct3;
        regIdx      rd;
        opcode      op;
    } rFmt;

    typedef struct packed {
        logic [11:0] imm;
        regIdx       rs1;
        logic [2:0]  funct3;
        regIdx       rd;
        opcode       op;
    } iFmt;

    typedef struct packed {
        logic [6:0] immHi;
        regIdx      rs2;
        regIdx      rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcode      op;
    } sFmt;

    // branch offset bits are scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        regIdx      rs2;
        regIdx      rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcode      op;
    } bFmt;

    typedef union packed {
        rFmt r;
        iFmt i;
        sFmt s;
        bFmt b;
    } instrWord;

endpackage

// ==== common/rvPipePkg.sv ====
package rvPipePkg;

    typedef struct packed {
        logic aluSrc;   // operand 2 is the immediate
        logic isImmOp;  // OP_IMM, funct7 only for shifts
        logic isBranch;
    } exCtrl;

    typedef struct packed {
        logic memRead;
        logic memWrite;
    } memCtrl;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrl;

    typedef struct packed {
        rvIsaPkg::word      pc;
        rvIsaPkg::instrWord instr;
    } ifIdReg;

    typedef struct packed {
        rvIsaPkg::word   pc;
        exCtrl           ex;
        memCtrl          mem;
        wbCtrl           wb;
        rvIsaPkg::word   rData1;
        rvIsaPkg::word   rData2;
        rvIsaPkg::word   imm;
        rvIsaPkg::regIdx rs1;
        rvIsaPkg::regIdx rs2;
        rvIsaPkg::regIdx rd;
        logic [2:0]      funct3;
        logic            funct7b5;
    } idExReg;

    typedef struct packed {
        memCtrl          mem;
        wbCtrl           wb;
        rvIsaPkg::word   aluOut;
        rvIsaPkg::word   storeData;
        rvIsaPkg::regIdx rd;
    } exMemReg;

    typedef struct packed {
        wbCtrl           wb;
        rvIsaPkg::word   loadData;
        rvIsaPkg::word   aluOut;
        rvIsaPkg::regIdx rd;
    } memWbReg;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwdSel;

    typedef struct packed {
        logic          ren;
        rvIsaPkg::word addr;
    } icacheReq;

    // same response shape from both caches
    typedef struct packed {
        logic          stall;
        rvIsaPkg::word rdata;
    } cacheRsp;

    typedef struct packed {
        logic          ren;
        logic          wen;
        rvIsaPkg::word addr;
        rvIsaPkg::word wdata;
    } dcacheReq;

endpackage

// ==== rvCore/rvRegFile.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rvRegFile (
    input  logic            clk,
    input  logic            rst_n,
    input  rvIsaPkg::regIdx rs1,
    input  rvIsaPkg::regIdx rs2,
    input  rvIsaPkg::regIdx rd,
    input  rvIsaPkg::word   wData,
    input  logic            regWrite,
    output rvIsaPkg::word   rData1,
    output rvIsaPkg::word   rData2
);

    rvIsaPkg::word regs [`RV_REGS];
    logic          wrEn;

    assign wrEn = regWrite && (rd != '0);   // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wrEn) begin
            regs[rd] <= wData;
        end
    end

    // write-first, decode sees this cycle's writeback
    assign rData1 = (rs1 == '0) ? '0 : (wrEn && rd == rs1) ? wData : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : (wrEn && rd == rs2) ? wData : regs[rs2];

endmodule

// ==== rvCore/rvDecode.sv ====
`timescale 1ns/100ps

module rvDecode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  logic               holdFront,
    input  logic               flush,
    input  rvPipePkg::ifIdReg  ifId,
    input  rvIsaPkg::word      rData1,
    input  rvIsaPkg::word      rData2,
    output rvIsaPkg::regIdx    rs1,
    output rvIsaPkg::regIdx    rs2,
    output rvPipePkg::idExReg  idEx
);

    rvIsaPkg::instrWord instr;
    rvPipePkg::exCtrl   exNext;
    rvPipePkg::memCtrl  memNext;
    rvPipePkg::wbCtrl   wbNext;
    rvIsaPkg::word      immNext;
    rvPipePkg::idExReg  idExNext;

    assign instr = ifId.instr;

    // register fields sit at the same bits in every format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    // main control and immediate select
    always_comb begin
        exNext  = '0;
        memNext = '0;
        wbNext  = '0;
        immNext = '0;
        case (instr.r.op)
            rvIsaPkg::OP_REG: begin
                wbNext.regWrite = 1'b1;
            end
            rvIsaPkg::OP_IMM: begin
                exNext.aluSrc   = 1'b1;
                exNext.isImmOp  = 1'b1;
                wbNext.regWrite = 1'b1;
                immNext         = rvIsaPkg::word'($signed(instr.i.imm));
            end
            rvIsaPkg::OP_LOAD: begin
                exNext.aluSrc   = 1'b1;
                memNext.memRead = 1'b1;
                wbNext.regWrite = 1'b1;
                wbNext.memToReg = 1'b1;
                immNext         = rvIsaPkg::word'($signed(instr.i.imm));
            end
            rvIsaPkg::OP_STORE: begin
                exNext.aluSrc    = 1'b1;
                memNext.memWrite = 1'b1;
                immNext = rvIsaPkg::word'($signed({instr.s.immHi, instr.s.immLo}));
            end
            rvIsaPkg::OP_BRANCH: begin
                exNext.isBranch = 1'b1;
                immNext = rvIsaPkg::word'($signed({instr.b.imm12, instr.b.imm11,
                                                   instr.b.imm10to5, instr.b.imm4to1, 1'b0}));
            end
            default: ;  // unknown opcode runs as a nop
        endcase
    end

    always_comb begin
        idExNext.pc       = ifId.pc;
        idExNext.ex       = exNext;
        idExNext.mem      = memNext;
        idExNext.wb       = wbNext;
        idExNext.rData1   = rData1;
        idExNext.rData2   = rData2;
        idExNext.imm      = immNext;
        idExNext.rs1      = instr.r.rs1;
        idExNext.rs2      = instr.r.rs2;
        idExNext.rd       = instr.r.rd;
        idExNext.funct3   = instr.r.funct3;
        idExNext.funct7b5 = instr.r.funct7[5];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (freeze) begin
            idEx <= idEx;
        end else if (holdFront || flush) begin
            idEx <= '0;     // bubble
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

// ==== rvCore/rvExecute.sv ====
`timescale 1ns/100ps

module rvExecute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  logic               flush,
    input  rvPipePkg::idExReg  idEx,
    input  rvIsaPkg::word      loadData,
    output rvPipePkg::exMemReg exMem,
    output rvPipePkg::memWbReg memWb,
    output rvIsaPkg::word      wbData,
    output logic               branchTaken,
    output rvIsaPkg::word      branchTarget
);

    rvPipePkg::fwdSel fwd1;
    rvPipePkg::fwdSel fwd2;
    rvIsaPkg::word    op1;
    rvIsaPkg::word    op2Fwd;
    rvIsaPkg::word    op2;
    rvIsaPkg::aluOp   aluSel;
    rvIsaPkg::word    aluOut;

    // memory stage wins over writeback and x0 is never forwarded
    function automatic rvPipePkg::fwdSel pickFwd(input rvIsaPkg::regIdx src);
        if (src == '0) begin
            return rvPipePkg::FWD_NONE;
        end
        if (exMem.wb.regWrite && exMem.rd == src) begin
            return rvPipePkg::FWD_MEM;
        end
        if (memWb.wb.regWrite && memWb.rd == src) begin
            return rvPipePkg::FWD_WB;
        end
        return rvPipePkg::FWD_NONE;
    endfunction

    function automatic rvIsaPkg::word fwdMux(input rvPipePkg::fwdSel sel,
                                             input rvIsaPkg::word regVal);
        case (sel)
            rvPipePkg::FWD_MEM: return exMem.aluOut;
            rvPipePkg::FWD_WB:  return wbData;
            default:            return regVal;
        endcase
    endfunction

    assign wbData = memWb.wb.memToReg ? memWb.loadData : memWb.aluOut;

    always_comb begin
        fwd1   = pickFwd(idEx.rs1);
        fwd2   = pickFwd(idEx.rs2);
        op1    = fwdMux(fwd1, idEx.rData1);
        op2Fwd = fwdMux(fwd2, idEx.rData2);
    end

    assign op2 = idEx.ex.aluSrc ? idEx.imm : op2Fwd;

    // loads and stores fall through to add
    always_comb begin
        aluSel = rvIsaPkg::ALU_ADD;
        if (!idEx.ex.aluSrc || idEx.ex.isImmOp) begin
            case (idEx.funct3)
                3'b000:  aluSel = (!idEx.ex.aluSrc && idEx.funct7b5) ? rvIsaPkg::ALU_SUB
                                                                     : rvIsaPkg::ALU_ADD;
                3'b001:  aluSel = rvIsaPkg::ALU_SLL;
                3'b010:  aluSel = rvIsaPkg::ALU_SLT;
                3'b100:  aluSel = rvIsaPkg::ALU_XOR;
                3'b101:  aluSel = idEx.funct7b5 ? rvIsaPkg::ALU_SRA : rvIsaPkg::ALU_SRL;
                3'b110:  aluSel = rvIsaPkg::ALU_OR;
                3'b111:  aluSel = rvIsaPkg::ALU_AND;
                default: aluSel = rvIsaPkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (aluSel)
            rvIsaPkg::ALU_SUB: aluOut = op1 - op2;
            rvIsaPkg::ALU_AND: aluOut = op1 & op2;
            rvIsaPkg::ALU_OR:  aluOut = op1 | op2;
            rvIsaPkg::ALU_XOR: aluOut = op1 ^ op2;
            rvIsaPkg::ALU_SLT: aluOut = rvIsaPkg::word'($signed(op1) < $signed(op2));
            rvIsaPkg::ALU_SLL: aluOut = op1 << op2[4:0];
            rvIsaPkg::ALU_SRL: aluOut = op1 >> op2[4:0];
            rvIsaPkg::ALU_SRA: aluOut = $signed(op1) >>> op2[4:0];
            default:           aluOut = op1 + op2;
        endcase
    end

    // funct3 bit 0 picks bne over beq
    assign branchTaken  = idEx.ex.isBranch & (idEx.funct3[0] ^ (op1 == op2Fwd));
    assign branchTarget = idEx.pc + idEx.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!freeze) begin
            exMem.mem <= idEx.mem;
            exMem.wb  <= idEx.wb;
            exMem.rd  <= idEx.rd;
            if (!flush) begin   // taken branch carries no result
                exMem.aluOut    <= aluOut;
                exMem.storeData <= op2Fwd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb.wb       <= exMem.wb;
            memWb.loadData <= loadData;
            memWb.aluOut   <= exMem.aluOut;
            memWb.rd       <= exMem.rd;
        end
    end

endmodule

// ==== rvCore/rvHazard.sv ====
`timescale 1ns/100ps

module rvHazard (
    input  rvIsaPkg::regIdx rs1,
    input  rvIsaPkg::regIdx rs2,
    input  rvIsaPkg::regIdx exRd,
    input  logic            exMemRead,
    input  logic            iStall,
    input  logic            dStall,
    input  logic            branchTaken,
    output logic            freeze,
    output logic            holdFront,
    output logic            flush
);

    logic loadUse;

    // either cache busy stops every stage
    assign freeze = iStall | dStall;

    // load result not ready for the instruction behind it
    assign loadUse = exMemRead && (exRd != '0) && ((exRd == rs1) || (exRd == rs2));

    assign holdFront = loadUse & ~freeze;
    assign flush     = branchTaken & ~freeze;   // drops IF/ID and ID/EX

endmodule

// ==== rvCore/rvCore.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rvCore (
    input  logic                clk,
    input  logic                rst_n,
    input  rvPipePkg::cacheRsp  icacheRsp,
    input  rvPipePkg::cacheRsp  dcacheRsp,
    output rvPipePkg::icacheReq icacheReq,
    output rvPipePkg::dcacheReq dcacheReq
);

    rvIsaPkg::word      pc;
    rvIsaPkg::word      pcNext;
    rvPipePkg::ifIdReg  ifId;
    rvPipePkg::idExReg  idEx;
    rvPipePkg::exMemReg exMem;
    rvPipePkg::memWbReg memWb;

    rvIsaPkg::regIdx    rs1;
    rvIsaPkg::regIdx    rs2;
    rvIsaPkg::word      rData1;
    rvIsaPkg::word      rData2;
    rvIsaPkg::word      wbData;
    rvIsaPkg::word      branchTarget;
    logic               branchTaken;
    logic               freeze;
    logic               holdFront;
    logic               flush;

    // fetch side
    assign icacheReq.ren  = 1'b1;
    assign icacheReq.addr = pc;

    // memory stage access straight from EX/MEM
    assign dcacheReq.ren   = exMem.mem.memRead;
    assign dcacheReq.wen   = exMem.mem.memWrite & ~icacheRsp.stall; // no repeat write while frozen
    assign dcacheReq.addr  = exMem.aluOut;
    assign dcacheReq.wdata = exMem.storeData;

    always_comb begin
        if (freeze || holdFront) begin
            pcNext = pc;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pc + `RV_PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifId <= '0;
        end else if (freeze) begin
            ifId <= ifId;
        end else if (flush) begin
            ifId <= '0;     // wrong-path fetch dropped
        end else if (!holdFront) begin
            ifId.pc    <= pc;
            ifId.instr <= icacheRsp.rdata;
        end
    end

    rvDecode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .freeze    (freeze),
        .holdFront (holdFront),
        .flush     (flush),
        .ifId      (ifId),
        .rData1    (rData1),
        .rData2    (rData2),
        .rs1       (rs1),
        .rs2       (rs2),
        .idEx      (idEx)
    );

    rvRegFile regFile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (memWb.rd),
        .wData    (wbData),
        .regWrite (memWb.wb.regWrite),
        .rData1   (rData1),
        .rData2   (rData2)
    );

    rvExecute execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze       (freeze),
        .flush        (flush),
        .idEx         (idEx),
        .loadData     (dcacheRsp.rdata),
        .exMem        (exMem),
        .memWb        (memWb),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    rvHazard hazard_i (
        .rs1         (rs1),
        .rs2         (rs2),
        .exRd        (idEx.rd),
        .exMemRead   (idEx.mem.memRead),
        .iStall      (icacheRsp.stall),
        .dStall      (dcacheRsp.stall),
        .branchTaken (branchTaken),
        .freeze      (freeze),
        .holdFront   (holdFront),
        .flush       (flush)
    );

endmodule

// ==== sim/tbCacheModel.sv ====
`timescale 1ns/100ps

module tbCacheModel (
    input  logic               clk,
    input  logic               ren,
    input  logic               wen,
    input  rvIsaPkg::word      addr,
    input  rvIsaPkg::word      wdata,
    input  logic               stall,
    output rvPipePkg::cacheRsp rsp
);

    localparam int WORDS = 256;

    rvIsaPkg::word mem [WORDS];
    logic [7:0]    idx;

    assign idx = addr[9:2];     // word addressed, 1 KB aliased

    // read data is useless while busy, so hand back something wrong
    always_comb begin
        rsp.stall = stall;
        rsp.rdata = (stall || !ren) ? ~mem[idx] : mem[idx];
    end

    always @(posedge clk) begin
        if (wen && !stall) begin
            mem[idx] <= wdata;
        end
    end

    // backdoor load from the testbench
    task automatic put(input logic [7:0] k, input rvIsaPkg::word val);
        mem[k] <= val;
    endtask

endmodule

// ==== sim/tbRvCore.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module tbRvCore;

    logic                clk;
    logic                rst_n;
    logic                iStall;
    logic                dStall;
    logic                stallOn;
    rvPipePkg::icacheReq iReq;
    rvPipePkg::dcacheReq dReq;
    rvPipePkg::cacheRsp  iRsp;
    rvPipePkg::cacheRsp  dRsp;

    rvIsaPkg::word shadow [`RV_REGS];  // expected register contents
    rvIsaPkg::word expAddr [$];
    rvIsaPkg::word expData [$];
    rvIsaPkg::word gotAddr [$];
    rvIsaPkg::word gotData [$];
    rvIsaPkg::word pcEmit;
    int            readsSeen;
    int            readsExp;
    int            errCount;
    int            errAtStart;
    int            testCount;
    int            testFails;

    rvCore dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .icacheRsp (iRsp),
        .dcacheRsp (dRsp),
        .icacheReq (iReq),
        .dcacheReq (dReq)
    );

    tbCacheModel imem_i (
        .clk   (clk),
        .ren   (iReq.ren),
        .wen   (1'b0),
        .addr  (iReq.addr),
        .wdata (32'd0),
        .stall (iStall),
        .rsp   (iRsp)
    );

    tbCacheModel dmem_i (
        .clk   (clk),
        .ren   (dReq.ren),
        .wen   (dReq.wen),
        .addr  (dReq.addr),
        .wdata (dReq.wdata),
        .stall (dStall),
        .rsp   (dRsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random busy cycles on both caches
    initial begin
        int unsigned seedInit;
        seedInit = $urandom(45);
        iStall = 1'b0;
        dStall = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            iStall = stallOn && (($urandom % 4) == 0);
            dStall = stallOn && (($urandom % 4) == 0);
        end
    end

    // a write lands at the next edge when these hold
    always @(negedge clk) begin
        if (rst_n && dReq.wen && !dRsp.stall) begin
            gotAddr.push_back(dReq.addr);
            gotData.push_back(dReq.wdata);
        end
        if (rst_n && dReq.ren && !dRsp.stall && !iRsp.stall) begin
            readsSeen++;    // one per load leaving the memory stage
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic rvIsaPkg::word aluRef(input rvIsaPkg::aluOp op, input rvIsaPkg::word a,
                                             input rvIsaPkg::word b);
        case (op)
            rvIsaPkg::ALU_SUB: return a - b;
            rvIsaPkg::ALU_AND: return a & b;
            rvIsaPkg::ALU_OR:  return a | b;
            rvIsaPkg::ALU_XOR: return a ^ b;
            rvIsaPkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rvIsaPkg::ALU_SLL: return a << b[4:0];
            rvIsaPkg::ALU_SRL: return a >> b[4:0];
            rvIsaPkg::ALU_SRA: return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0);
            default:           return a + b;
        endcase
    endfunction

    function automatic logic [2:0] funct3Of(input rvIsaPkg::aluOp op);
        case (op)
            rvIsaPkg::ALU_SLL:                   return 3'b001;
            rvIsaPkg::ALU_SLT:                   return 3'b010;
            rvIsaPkg::ALU_XOR:                   return 3'b100;
            rvIsaPkg::ALU_SRL, rvIsaPkg::ALU_SRA: return 3'b101;
            rvIsaPkg::ALU_OR:                    return 3'b110;
            rvIsaPkg::ALU_AND:                   return 3'b111;
            default:                             return 3'b000;
        endcase
    endfunction

    function automatic void setReg(input rvIsaPkg::regIdx rd, input rvIsaPkg::word val);
        if (rd != 5'd0) begin
            shadow[rd] = val;
        end
    endfunction

    task automatic emit(input rvIsaPkg::word w);
        imem_i.put(pcEmit[9:2], w);
        pcEmit = pcEmit + `RV_PC_STEP;
    endtask

    task automatic opR(input rvIsaPkg::aluOp op, input rvIsaPkg::regIdx rd,
                       input rvIsaPkg::regIdx rs1, input rvIsaPkg::regIdx rs2);
        rvIsaPkg::instrWord iw;
        iw.r.funct7 = (op == rvIsaPkg::ALU_SUB || op == rvIsaPkg::ALU_SRA) ? 7'b0100000 : 7'b0;
        iw.r.rs2    = rs2;
        iw.r.rs1    = rs1;
        iw.r.funct3 = funct3Of(op);
        iw.r.rd     = rd;
        iw.r.op     = rvIsaPkg::OP_REG;
        emit(iw);
        setReg(rd, aluRef(op, shadow[rs1], shadow[rs2]));
    endtask

    task automatic opI(input rvIsaPkg::aluOp op, input rvIsaPkg::regIdx rd,
                       input rvIsaPkg::regIdx rs1, input int imm);
        rvIsaPkg::instrWord iw;
        iw.i.imm    = (op == rvIsaPkg::ALU_SRA) ? {7'b0100000, imm[4:0]} : imm[11:0];
        iw.i.rs1    = rs1;
        iw.i.funct3 = funct3Of(op);
        iw.i.rd     = rd;
        iw.i.op     = rvIsaPkg::OP_IMM;
        emit(iw);
        setReg(rd, aluRef(op, shadow[rs1], rvIsaPkg::word'(imm)));
    endtask

    // lw rd, addr(x0) with the value the test knows sits there
    task automatic loadWord(input rvIsaPkg::regIdx rd, input int addr, input rvIsaPkg::word val);
        rvIsaPkg::instrWord iw;
        iw.i.imm    = addr[11:0];
        iw.i.rs1    = 5'd0;
        iw.i.funct3 = 3'b010;
        iw.i.rd     = rd;
        iw.i.op     = rvIsaPkg::OP_LOAD;
        emit(iw);
        setReg(rd, val);
        readsExp++;
    endtask

    task automatic storeWord(input rvIsaPkg::regIdx src, input int addr, input logic expected);
        rvIsaPkg::instrWord iw;
        iw.s.immHi  = addr[11:5];
        iw.s.rs2    = src;
        iw.s.rs1    = 5'd0;
        iw.s.funct3 = 3'b010;
        iw.s.immLo  = addr[4:0];
        iw.s.op     = rvIsaPkg::OP_STORE;
        emit(iw);
        if (expected) begin
            expAddr.push_back(rvIsaPkg::word'(addr));
            expData.push_back(shadow[src]);
        end
    endtask

    // branch over two marker stores
    task automatic branchSkip(input logic isBne, input rvIsaPkg::regIdx a,
                              input rvIsaPkg::regIdx b, input rvIsaPkg::regIdx mark);
        rvIsaPkg::instrWord iw;
        logic               taken;
        logic [12:0]        off;
        off   = 13'd12;
        taken = isBne ? (shadow[a] != shadow[b]) : (shadow[a] == shadow[b]);
        iw.b.imm12    = off[12];
        iw.b.imm10to5 = off[10:5];
        iw.b.rs2      = b;
        iw.b.rs1      = a;
        iw.b.funct3   = {2'b00, isBne};
        iw.b.imm4to1  = off[4:1];
        iw.b.imm11    = off[11];
        iw.b.op       = rvIsaPkg::OP_BRANCH;
        emit(iw);
        storeWord(mark, 'h3F0, !taken);
        storeWord(mark, 'h3F4, !taken);
    endtask

    task automatic checkWord(input string name, input rvIsaPkg::word got,
                             input rvIsaPkg::word exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkAddr(input string name, input rvIsaPkg::word got,
                             input rvIsaPkg::word exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errCount++;
        end
    endtask

    // reset held over two edges with memories refilled in between
    task automatic beginTest(input logic stalls);
        step();
        rst_n      = 1'b0;
        stallOn    = stalls;
        errAtStart = errCount;
        step();
        expAddr.delete();
        expData.delete();
        gotAddr.delete();
        gotData.delete();
        readsSeen = 0;
        readsExp  = 0;
        for (int k = 0; k < 256; k++) begin
            imem_i.put(8'(k), {4'd0, 8'(k), 13'd0, 7'b0010011});  // addi x0, x0, k
            dmem_i.put(8'(k), 32'hC0DE_0000 ^ (rvIsaPkg::word'(k) * 32'h0001_0203));
        end
        for (int r = 0; r < `RV_REGS; r++) begin
            shadow[r] = '0;
        end
        pcEmit = `RV_RESET_PC;
    endtask

    task automatic finishTest(input string name);
        int cycles;
        step();
        rst_n  = 1'b1;
        cycles = 0;
        while (gotAddr.size() < expAddr.size() && cycles < 400) begin
            step();
            cycles++;
        end
        if (gotAddr.size() < expAddr.size()) begin
            $display("%s timed out with %0d of %0d stores seen", name, gotAddr.size(),
                     expAddr.size());
            errCount++;
        end else begin
            for (int n = 0; n < 16; n++) begin
                step();     // room for a stray store
            end
            if (gotAddr.size() != expAddr.size()) begin
                $display("%s saw %0d stores but expected only %0d", name, gotAddr.size(),
                         expAddr.size());
                errCount++;
            end
            for (int k = 0; k < expAddr.size(); k++) begin
                checkAddr($sformatf("dcacheReq.addr[%0d]", k), gotAddr[k], expAddr[k]);
                checkWord($sformatf("dcacheReq.wdata[%0d]", k), gotData[k], expData[k]);
            end
            checkCount("dcacheReq.ren reads", readsSeen, readsExp);
        end
        testCount++;
        if (errCount != errAtStart) begin
            testFails++;
        end
        $display("test %-16s %s", name, (errCount == errAtStart) ? "pass" : "fail");
    endtask

    task automatic aluChain(input logic stalls);
        beginTest(stalls);
        opI(rvIsaPkg::ALU_ADD, 5'd1, 5'd0, 'h123);
        opI(rvIsaPkg::ALU_ADD, 5'd2, 5'd1, -69);
        opR(rvIsaPkg::ALU_ADD, 5'd3, 5'd1, 5'd2);
        storeWord(5'd3, 'h100, 1'b1);   // store data from the memory stage
        opR(rvIsaPkg::ALU_SUB, 5'd4, 5'd3, 5'd1);
        opR(rvIsaPkg::ALU_AND, 5'd5, 5'd4, 5'd3);
        opR(rvIsaPkg::ALU_OR,  5'd6, 5'd5, 5'd1);
        opR(rvIsaPkg::ALU_XOR, 5'd7, 5'd6, 5'd2);
        opI(rvIsaPkg::ALU_ADD, 5'd8, 5'd0, -5);
        opR(rvIsaPkg::ALU_SLT, 5'd9, 5'd8, 5'd7);
        opR(rvIsaPkg::ALU_SLL, 5'd10, 5'd7, 5'd9);
        opR(rvIsaPkg::ALU_SRL, 5'd11, 5'd8, 5'd9);
        opR(rvIsaPkg::ALU_SRA, 5'd12, 5'd8, 5'd9);
        opI(rvIsaPkg::ALU_AND, 5'd13, 5'd12, 'h7F0);
        opI(rvIsaPkg::ALU_OR,  5'd14, 5'd13, 'h00F);
        opI(rvIsaPkg::ALU_XOR, 5'd15, 5'd14, -1);
        opI(rvIsaPkg::ALU_SLT, 5'd16, 5'd15, 3);
        opI(rvIsaPkg::ALU_SLL, 5'd17, 5'd7, 7);
        opI(rvIsaPkg::ALU_SRL, 5'd18, 5'd15, 4);
        opI(rvIsaPkg::ALU_SRA, 5'd19, 5'd15, 4);
        for (int r = 4; r <= 19; r++) begin
            storeWord(5'(r), 'h100 + 4 * r, 1'b1);
        end
        finishTest(stalls ? "aluChainStall" : "aluChain");
    endtask

    task automatic loadStore();
        beginTest(1'b0);
        dmem_i.put(8'h80, 32'h1357_9BDF);      // word at 0x200
        opI(rvIsaPkg::ALU_ADD, 5'd2, 5'd0, 'h55);
        loadWord(5'd1, 'h200, 32'h1357_9BDF);
        opR(rvIsaPkg::ALU_ADD, 5'd3, 5'd1, 5'd2);   // load-use
        storeWord(5'd3, 'h210, 1'b1);
        storeWord(5'd3, 'h214, 1'b1);
        loadWord(5'd4, 'h214, shadow[3]);
        storeWord(5'd4, 'h218, 1'b1);               // stored word straight from a load
        finishTest("loadStore");
    endtask

    task automatic branches(input logic stalls);
        beginTest(stalls);
        opI(rvIsaPkg::ALU_ADD, 5'd1, 5'd0, 5);
        opI(rvIsaPkg::ALU_ADD, 5'd2, 5'd0, 5);
        opI(rvIsaPkg::ALU_ADD, 5'd3, 5'd0, 9);
        opI(rvIsaPkg::ALU_ADD, 5'd9, 5'd0, 'h666);  // marker value
        branchSkip(1'b0, 5'd1, 5'd2, 5'd9);         // beq taken
        storeWord(5'd1, 'h300, 1'b1);
        branchSkip(1'b1, 5'd1, 5'd2, 5'd9);         // bne falls through
        storeWord(5'd3, 'h304, 1'b1);
        opI(rvIsaPkg::ALU_ADD, 5'd4, 5'd3, 1);
        branchSkip(1'b1, 5'd4, 5'd0, 5'd9);         // taken only with x4 forwarded
        storeWord(5'd4, 'h308, 1'b1);
        finishTest(stalls ? "branchesStall" : "branches");
    endtask

    task automatic zeroReg();
        beginTest(1'b0);
        opI(rvIsaPkg::ALU_ADD, 5'd1, 5'd0, 'h3C);
        opI(rvIsaPkg::ALU_ADD, 5'd0, 5'd1, 7);
        storeWord(5'd0, 'h380, 1'b1);
        opR(rvIsaPkg::ALU_ADD, 5'd0, 5'd1, 5'd1);
        opR(rvIsaPkg::ALU_ADD, 5'd2, 5'd0, 5'd1);
        storeWord(5'd2, 'h384, 1'b1);
        storeWord(5'd0, 'h388, 1'b1);
        loadWord(5'd0, 'h100, 32'd0);               // loaded value dropped
        storeWord(5'd0, 'h38C, 1'b1);
        finishTest("zeroReg");
    endtask

    initial begin
        rst_n     = 1'b0;
        stallOn   = 1'b0;
        errCount  = 0;
        testCount = 0;
        testFails = 0;
        readsSeen = 0;
        readsExp  = 0;
        pcEmit    = `RV_RESET_PC;
        aluChain(1'b0);
        loadStore();
        branches(1'b0);
        zeroReg();
        aluChain(1'b1);
        branches(1'b1);
        $display("tests run %0d, failed %0d, errors %0d", testCount, testFails, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/rvIsaPkg.sv
common/rvPipePkg.sv
rvCore/rvRegFile.sv
rvCore/rvDecode.sv
rvCore/rvExecute.sv
rvCore/rvHazard.sv
rvCore/rvCore.sv
sim/tbCacheModel.sv
sim/tbRvCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f filelist.f --top-module tbRvCore -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VtbRvCore)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$out"; then
    exit 0
fi
exit 1
